//--- verilog/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

  // Datapath word and architectural register file
  localparam int WORD_W = 16;
  localparam int REG_N = 8;
  localparam int REG_W = $clog2(REG_N);

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0] reg_t;

  // The top opcode bit selects the logic station
  typedef enum logic [2:0] {
    OP_ADD  = 3'b000,
    OP_SUB  = 3'b001,
    OP_MOVI = 3'b010,
    OP_AND  = 3'b100,
    OP_OR   = 3'b101,
    OP_XOR  = 3'b110
  } opcode_t;

  // Reservation station geometry
  localparam int RS_DEPTH = 4;
  localparam int RS_IDX_W = $clog2(RS_DEPTH);

  typedef logic [RS_IDX_W-1:0] rs_idx_t;

  // A tag is the station id above the entry index
  typedef logic [RS_IDX_W:0] tag_t;

  localparam logic STATION_ARITH = 1'b0;
  localparam logic STATION_LOGIC = 1'b1;

  // Cycles from issue to the final stage of each unit
  localparam int LATENCY_ARITH = 2;
  localparam int LATENCY_LOGIC = 1;

  // Instruction queue
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

endpackage

`default_nettype wire

//--- verilog/inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fifo (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     push,
  input  wire tomasulo_pkg::opcode_t push_op,
  input  wire tomasulo_pkg::reg_t push_ra_1,
  input  wire tomasulo_pkg::reg_t push_ra_0,
  input  wire tomasulo_pkg::reg_t push_wa,
  input  wire tomasulo_pkg::word_t push_imm,
  input  wire                     pop,
  output logic                    full_r,
  output logic                    head_vld,
  output tomasulo_pkg::opcode_t   head_op,
  output tomasulo_pkg::reg_t      head_ra_1,
  output tomasulo_pkg::reg_t      head_ra_0,
  output tomasulo_pkg::reg_t      head_wa,
  output tomasulo_pkg::word_t     head_imm
);

  localparam int PW = tomasulo_pkg::FIFO_PTR_W;

  // Storage is split per field
  tomasulo_pkg::opcode_t op_mem  [tomasulo_pkg::FIFO_DEPTH];
  tomasulo_pkg::reg_t    ra1_mem [tomasulo_pkg::FIFO_DEPTH];
  tomasulo_pkg::reg_t    ra0_mem [tomasulo_pkg::FIFO_DEPTH];
  tomasulo_pkg::reg_t    wa_mem  [tomasulo_pkg::FIFO_DEPTH];
  tomasulo_pkg::word_t   imm_mem [tomasulo_pkg::FIFO_DEPTH];

  // Pointers carry one extra wrap bit above the index
  logic [PW:0] wr_ptr_r;
  logic [PW:0] rd_ptr_r;
  logic [PW:0] wr_ptr_w;
  logic [PW:0] rd_ptr_w;
  logic        empty_r;

  assign wr_ptr_w = wr_ptr_r + {{PW{1'b0}}, push};
  assign rd_ptr_w = rd_ptr_r + {{PW{1'b0}}, pop};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      empty_r  <= 1'b1;
      full_r   <= 1'b0;
    end
    else
    begin
      wr_ptr_r <= wr_ptr_w;
      rd_ptr_r <= rd_ptr_w;
      // Flags look at the next pointers so they are valid as registers
      empty_r  <= (rd_ptr_w == wr_ptr_w);
      full_r   <= (rd_ptr_w[PW] != wr_ptr_w[PW]) && (rd_ptr_w[PW-1:0] == wr_ptr_w[PW-1:0]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      op_mem[wr_ptr_r[PW-1:0]]  <= push_op;
      ra1_mem[wr_ptr_r[PW-1:0]] <= push_ra_1;
      ra0_mem[wr_ptr_r[PW-1:0]] <= push_ra_0;
      wa_mem[wr_ptr_r[PW-1:0]]  <= push_wa;
      imm_mem[wr_ptr_r[PW-1:0]] <= push_imm;
    end
  end

  // The head is read straight from the array
  assign head_vld  = ~empty_r;
  assign head_op   = op_mem[rd_ptr_r[PW-1:0]];
  assign head_ra_1 = ra1_mem[rd_ptr_r[PW-1:0]];
  assign head_ra_0 = ra0_mem[rd_ptr_r[PW-1:0]];
  assign head_wa   = wa_mem[rd_ptr_r[PW-1:0]];
  assign head_imm  = imm_mem[rd_ptr_r[PW-1:0]];

endmodule

`default_nettype wire

//--- verilog/dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module dispatcher (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      inst_vld,
  input  wire tomasulo_pkg::opcode_t inst_op,
  input  wire tomasulo_pkg::reg_t  inst_ra_1,
  input  wire tomasulo_pkg::reg_t  inst_ra_0,
  input  wire tomasulo_pkg::reg_t  inst_wa,
  input  wire tomasulo_pkg::word_t inst_imm,
  output logic                     inst_adv,
  input  wire                      arith_free,
  input  wire tomasulo_pkg::rs_idx_t arith_free_idx,
  input  wire                      logic_free,
  input  wire tomasulo_pkg::rs_idx_t logic_free_idx,
  output logic                     arith_dis_vld,
  output logic                     logic_dis_vld,
  output tomasulo_pkg::opcode_t    dis_op,
  output tomasulo_pkg::word_t      dis_imm,
  output tomasulo_pkg::reg_t       dis_wa,
  output tomasulo_pkg::tag_t       dis_tag,
  output logic [1:0]               dis_src_rdy,
  output tomasulo_pkg::word_t [1:0] dis_src_val,
  output tomasulo_pkg::tag_t [1:0] dis_src_tag,
  input  wire                      cdb_vld_r,
  input  wire tomasulo_pkg::tag_t  cdb_tag_r,
  input  wire tomasulo_pkg::word_t cdb_data_r,
  input  wire tomasulo_pkg::tag_t  lookup_tag,
  output tomasulo_pkg::reg_t       lookup_wa
);

  // Architectural values with their rename state
  tomasulo_pkg::word_t            val_r [tomasulo_pkg::REG_N];
  tomasulo_pkg::tag_t             tag_r [tomasulo_pkg::REG_N];
  logic [tomasulo_pkg::REG_N-1:0] busy_r;

  // Destination register of every tag in flight
  tomasulo_pkg::reg_t wa_tab_r [2*tomasulo_pkg::RS_DEPTH];

  logic                      is_logic;
  tomasulo_pkg::tag_t        new_tag;
  tomasulo_pkg::reg_t [1:0]  src_ra;
  logic [1:0]                src_rdy_w;
  tomasulo_pkg::word_t [1:0] src_val_w;
  tomasulo_pkg::tag_t [1:0]  src_tag_w;

  always_comb
  begin
    is_logic = inst_op inside {tomasulo_pkg::OP_AND, tomasulo_pkg::OP_OR, tomasulo_pkg::OP_XOR};
    // Take the head only when its station has room
    inst_adv = inst_vld & (is_logic ? logic_free : arith_free);
    new_tag  = is_logic ? {tomasulo_pkg::STATION_LOGIC, logic_free_idx}
                        : {tomasulo_pkg::STATION_ARITH, arith_free_idx};

    // Operand a comes from ra_0 and operand b from ra_1
    src_ra[0] = inst_ra_0;
    src_ra[1] = inst_ra_1;
    for (int s = 0; s < 2; s++)
    begin
      src_rdy_w[s] = 1'b1;
      src_val_w[s] = val_r[src_ra[s]];
      src_tag_w[s] = tag_r[src_ra[s]];
      if (inst_op != tomasulo_pkg::OP_MOVI && busy_r[src_ra[s]])
      begin
        // A producer broadcasting right now is forwarded directly
        if (cdb_vld_r && cdb_tag_r == tag_r[src_ra[s]])
          src_val_w[s] = cdb_data_r;
        else
          src_rdy_w[s] = 1'b0;
      end
    end
  end

  // Register file update, a new rename beats a broadcast to the same register
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_r <= '0;
      for (int r = 0; r < tomasulo_pkg::REG_N; r++)
        val_r[r] <= '0;
    end
    else
    begin
      for (int r = 0; r < tomasulo_pkg::REG_N; r++)
      begin
        if (inst_adv && inst_wa == tomasulo_pkg::reg_t'(r))
          busy_r[r] <= 1'b1;
        else if (cdb_vld_r && busy_r[r] && tag_r[r] == cdb_tag_r)
        begin
          busy_r[r] <= 1'b0;
          val_r[r]  <= cdb_data_r;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (inst_adv)
      tag_r[inst_wa] <= new_tag;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arith_dis_vld <= 1'b0;
      logic_dis_vld <= 1'b0;
    end
    else
    begin
      arith_dis_vld <= inst_adv & ~is_logic;
      logic_dis_vld <= inst_adv & is_logic;
    end
  end

  // Dispatch payload lands one cycle after the head is taken
  always_ff @(posedge clk)
  begin
    if (inst_adv)
    begin
      dis_op      <= inst_op;
      dis_imm     <= inst_imm;
      dis_wa      <= inst_wa;
      dis_tag     <= new_tag;
      dis_src_rdy <= src_rdy_w;
      dis_src_val <= src_val_w;
      dis_src_tag <= src_tag_w;
    end
  end

  always_ff @(posedge clk)
  begin
    if (arith_dis_vld || logic_dis_vld)
      wa_tab_r[dis_tag] <= dis_wa;
  end

  // The arbiter reads the destination of the result it grants
  assign lookup_wa = wa_tab_r[lookup_tag];

endmodule

`default_nettype wire

//--- verilog/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
  parameter logic STATION_ID = tomasulo_pkg::STATION_ARITH
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      dis_vld,
  input  wire tomasulo_pkg::opcode_t dis_op,
  input  wire tomasulo_pkg::word_t dis_imm,
  input  wire [1:0]                dis_src_rdy,
  input  wire tomasulo_pkg::word_t [1:0] dis_src_val,
  input  wire tomasulo_pkg::tag_t [1:0] dis_src_tag,
  output logic                     free,
  output tomasulo_pkg::rs_idx_t    free_idx,
  input  wire                      cdb_vld_r,
  input  wire tomasulo_pkg::tag_t  cdb_tag_r,
  input  wire tomasulo_pkg::word_t cdb_data_r,
  input  wire                      iss_ready,
  output logic                     iss_vld,
  output tomasulo_pkg::opcode_t    iss_op,
  output tomasulo_pkg::word_t      iss_a,
  output tomasulo_pkg::word_t      iss_b,
  output tomasulo_pkg::word_t      iss_imm,
  output tomasulo_pkg::tag_t       iss_tag
);

  localparam int N = tomasulo_pkg::RS_DEPTH;

  // An entry holds its tag from dispatch until its own broadcast
  logic [N-1:0]              vld_r;
  logic [N-1:0]              issued_r;
  tomasulo_pkg::opcode_t     op_r   [N];
  tomasulo_pkg::word_t       imm_r  [N];
  logic [1:0]                rdy_r  [N];
  tomasulo_pkg::word_t [1:0] val_r  [N];
  tomasulo_pkg::tag_t [1:0]  wait_r [N];

  // Index offered last cycle, which a dispatch now fills
  tomasulo_pkg::rs_idx_t alloc_idx_r;

  logic [N-1:0]          free_mask;
  logic [N-1:0]          ready_mask;
  tomasulo_pkg::rs_idx_t iss_sel;

  always_comb
  begin
    free_mask = ~vld_r;
    if (dis_vld)
      free_mask[alloc_idx_r] = 1'b0;
    free     = |free_mask;
    free_idx = '0;
    iss_sel  = '0;
    // Scan downwards so the lowest index wins
    for (int i = N - 1; i >= 0; i--)
    begin
      ready_mask[i] = vld_r[i] & ~issued_r[i] & (&rdy_r[i]);
      if (free_mask[i])
        free_idx = tomasulo_pkg::rs_idx_t'(i);
      if (ready_mask[i])
        iss_sel = tomasulo_pkg::rs_idx_t'(i);
    end
    iss_vld = iss_ready & (|ready_mask);
    iss_op  = op_r[iss_sel];
    iss_a   = val_r[iss_sel][0];
    iss_b   = val_r[iss_sel][1];
    iss_imm = imm_r[iss_sel];
    iss_tag = {STATION_ID, iss_sel};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      vld_r    <= '0;
      issued_r <= '0;
    end
    else
    begin
      for (int i = 0; i < N; i++)
      begin
        if (dis_vld && alloc_idx_r == tomasulo_pkg::rs_idx_t'(i))
        begin
          vld_r[i]    <= 1'b1;
          issued_r[i] <= 1'b0;
        end
        else if (cdb_vld_r && cdb_tag_r == {STATION_ID, tomasulo_pkg::rs_idx_t'(i)})
          vld_r[i] <= 1'b0;
        else if (iss_vld && iss_sel == tomasulo_pkg::rs_idx_t'(i))
          issued_r[i] <= 1'b1;
      end
    end
  end

  // Operands are captured from the CDB even on the write cycle
  always_ff @(posedge clk)
  begin
    alloc_idx_r <= free_idx;
    for (int i = 0; i < N; i++)
    begin
      if (dis_vld && alloc_idx_r == tomasulo_pkg::rs_idx_t'(i))
      begin
        op_r[i]  <= dis_op;
        imm_r[i] <= dis_imm;
      end
      for (int s = 0; s < 2; s++)
      begin
        if (dis_vld && alloc_idx_r == tomasulo_pkg::rs_idx_t'(i))
        begin
          wait_r[i][s] <= dis_src_tag[s];
          rdy_r[i][s]  <= dis_src_rdy[s] | (cdb_vld_r && cdb_tag_r == dis_src_tag[s]);
          if (!dis_src_rdy[s] && cdb_vld_r && cdb_tag_r == dis_src_tag[s])
            val_r[i][s] <= cdb_data_r;
          else
            val_r[i][s] <= dis_src_val[s];
        end
        else if (vld_r[i] && !rdy_r[i][s] && cdb_vld_r && cdb_tag_r == wait_r[i][s])
        begin
          rdy_r[i][s] <= 1'b1;
          val_r[i][s] <= cdb_data_r;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/exe_arith.sv
`timescale 1ns/1ps
`default_nettype none

module exe_arith #(
  parameter int LATENCY = tomasulo_pkg::LATENCY_ARITH
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      iss_vld,
  input  wire tomasulo_pkg::opcode_t iss_op,
  input  wire tomasulo_pkg::word_t iss_a,
  input  wire tomasulo_pkg::word_t iss_b,
  input  wire tomasulo_pkg::word_t iss_imm,
  input  wire tomasulo_pkg::tag_t  iss_tag,
  output logic                     iss_ready,
  input  wire                      cdb_gnt,
  output logic                     cdb_req,
  output tomasulo_pkg::tag_t       res_tag,
  output tomasulo_pkg::word_t      res_data
);

  logic [LATENCY-1:0]  vld_r;
  tomasulo_pkg::tag_t  tag_r  [LATENCY];
  tomasulo_pkg::word_t data_r [LATENCY];
  tomasulo_pkg::word_t res_w;
  logic                stall;

  // Results wrap modulo the word width
  always_comb
  begin
    case (iss_op)
      tomasulo_pkg::OP_SUB:  res_w = iss_a - iss_b;
      tomasulo_pkg::OP_MOVI: res_w = iss_imm;
      default:               res_w = iss_a + iss_b;
    endcase
  end

  // A final stage waiting on the CDB freezes every stage behind it
  assign stall     = vld_r[LATENCY-1] & ~cdb_gnt;
  assign iss_ready = ~stall;
  assign cdb_req   = vld_r[LATENCY-1];
  assign res_tag   = tag_r[LATENCY-1];
  assign res_data  = data_r[LATENCY-1];

  always_ff @(posedge clk)
  begin
    if (rst)
      vld_r <= '0;
    else if (!stall)
    begin
      vld_r[0] <= iss_vld;
      for (int k = 1; k < LATENCY; k++)
        vld_r[k] <= vld_r[k-1];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      tag_r[0]  <= iss_tag;
      data_r[0] <= res_w;
      for (int k = 1; k < LATENCY; k++)
      begin
        tag_r[k]  <= tag_r[k-1];
        data_r[k] <= data_r[k-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/exe_logic.sv
`timescale 1ns/1ps
`default_nettype none

module exe_logic #(
  parameter int LATENCY = tomasulo_pkg::LATENCY_LOGIC
) (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      iss_vld,
  input  wire tomasulo_pkg::opcode_t iss_op,
  input  wire tomasulo_pkg::word_t iss_a,
  input  wire tomasulo_pkg::word_t iss_b,
  input  wire tomasulo_pkg::word_t iss_imm,
  input  wire tomasulo_pkg::tag_t  iss_tag,
  output logic                     iss_ready,
  input  wire                      cdb_gnt,
  output logic                     cdb_req,
  output tomasulo_pkg::tag_t       res_tag,
  output tomasulo_pkg::word_t      res_data
);

  logic [LATENCY-1:0]  vld_r;
  tomasulo_pkg::tag_t  tag_r  [LATENCY];
  tomasulo_pkg::word_t data_r [LATENCY];
  tomasulo_pkg::word_t res_w;
  logic                stall;

  // An opcode outside the logic group passes the immediate through
  always_comb
  begin
    case (iss_op)
      tomasulo_pkg::OP_AND: res_w = iss_a & iss_b;
      tomasulo_pkg::OP_OR:  res_w = iss_a | iss_b;
      tomasulo_pkg::OP_XOR: res_w = iss_a ^ iss_b;
      default:              res_w = iss_imm;
    endcase
  end

  assign stall     = vld_r[LATENCY-1] & ~cdb_gnt;
  assign iss_ready = ~stall;
  assign cdb_req   = vld_r[LATENCY-1];
  assign res_tag   = tag_r[LATENCY-1];
  assign res_data  = data_r[LATENCY-1];

  always_ff @(posedge clk)
  begin
    if (rst)
      vld_r <= '0;
    else if (!stall)
    begin
      vld_r[0] <= iss_vld;
      for (int k = 1; k < LATENCY; k++)
        vld_r[k] <= vld_r[k-1];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
    begin
      tag_r[0]  <= iss_tag;
      data_r[0] <= res_w;
      for (int k = 1; k < LATENCY; k++)
      begin
        tag_r[k]  <= tag_r[k-1];
        data_r[k] <= data_r[k-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
  input  wire                      clk,
  input  wire                      rst,
  input  wire [1:0]                req,
  input  wire tomasulo_pkg::tag_t  tag_0,
  input  wire tomasulo_pkg::word_t data_0,
  input  wire tomasulo_pkg::tag_t  tag_1,
  input  wire tomasulo_pkg::word_t data_1,
  output logic [1:0]               gnt,
  output tomasulo_pkg::tag_t       lookup_tag,
  input  wire tomasulo_pkg::reg_t  lookup_wa,
  output logic                     cdb_vld_r,
  output tomasulo_pkg::tag_t       cdb_tag_r,
  output tomasulo_pkg::reg_t       cdb_wa_r,
  output tomasulo_pkg::word_t      cdb_data_r
);

  // Set when requester 1 wins a tie
  logic prio_r;

  always_comb
  begin
    gnt = 2'b00;
    if (req[1] && (prio_r || !req[0]))
      gnt[1] = 1'b1;
    else if (req[0])
      gnt[0] = 1'b1;
    lookup_tag = gnt[1] ? tag_1 : tag_0;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prio_r    <= 1'b0;
      cdb_vld_r <= 1'b0;
    end
    else
    begin
      cdb_vld_r <= |req;
      // The requester just served drops to lowest priority
      if (|req)
        prio_r <= gnt[0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (|req)
    begin
      cdb_tag_r  <= lookup_tag;
      cdb_wa_r   <= lookup_wa;
      cdb_data_r <= gnt[1] ? data_1 : data_0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/tomasulo.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      in_pass,
  input  wire tomasulo_pkg::opcode_t in_inst_op,
  input  wire tomasulo_pkg::reg_t  in_inst_ra_1,
  input  wire tomasulo_pkg::reg_t  in_inst_ra_0,
  input  wire tomasulo_pkg::reg_t  in_inst_wa,
  input  wire tomasulo_pkg::word_t in_imm,
  output logic                     in_accept,
  output logic                     out_vld_r,
  output tomasulo_pkg::reg_t       out_wa_r,
  output tomasulo_pkg::word_t      out_wdata_r
);

  logic                      full_r;
  logic                      push;
  logic                      inst_vld;
  logic                      inst_adv;
  tomasulo_pkg::opcode_t     inst_op;
  tomasulo_pkg::reg_t        inst_ra_1;
  tomasulo_pkg::reg_t        inst_ra_0;
  tomasulo_pkg::reg_t        inst_wa;
  tomasulo_pkg::word_t       inst_imm;
  logic                      arith_free;
  logic                      logic_free;
  tomasulo_pkg::rs_idx_t     arith_free_idx;
  tomasulo_pkg::rs_idx_t     logic_free_idx;
  logic                      arith_dis_vld;
  logic                      logic_dis_vld;
  tomasulo_pkg::opcode_t     dis_op;
  tomasulo_pkg::word_t       dis_imm;
  logic [1:0]                dis_src_rdy;
  tomasulo_pkg::word_t [1:0] dis_src_val;
  tomasulo_pkg::tag_t [1:0]  dis_src_tag;
  logic                      arith_iss_vld;
  logic                      logic_iss_vld;
  logic                      arith_iss_ready;
  logic                      logic_iss_ready;
  tomasulo_pkg::opcode_t     arith_iss_op;
  tomasulo_pkg::opcode_t     logic_iss_op;
  tomasulo_pkg::word_t       arith_iss_a;
  tomasulo_pkg::word_t       arith_iss_b;
  tomasulo_pkg::word_t       arith_iss_imm;
  tomasulo_pkg::word_t       logic_iss_a;
  tomasulo_pkg::word_t       logic_iss_b;
  tomasulo_pkg::word_t       logic_iss_imm;
  tomasulo_pkg::tag_t        arith_iss_tag;
  tomasulo_pkg::tag_t        logic_iss_tag;
  logic [1:0]                req;
  logic [1:0]                gnt;
  tomasulo_pkg::tag_t        arith_res_tag;
  tomasulo_pkg::tag_t        logic_res_tag;
  tomasulo_pkg::word_t       arith_res_data;
  tomasulo_pkg::word_t       logic_res_data;
  tomasulo_pkg::tag_t        lookup_tag;
  tomasulo_pkg::reg_t        lookup_wa;
  logic                      cdb_vld_r;
  tomasulo_pkg::tag_t        cdb_tag_r;
  tomasulo_pkg::reg_t        cdb_wa_r;
  tomasulo_pkg::word_t       cdb_data_r;

  assign in_accept   = ~full_r;
  assign push        = in_pass & in_accept;
  // Every broadcast on the CDB is also a core output
  assign out_vld_r   = cdb_vld_r;
  assign out_wa_r    = cdb_wa_r;
  assign out_wdata_r = cdb_data_r;

  inst_fifo u_fifo (
    .clk(clk), .rst(rst), .push(push), .push_op(in_inst_op),
    .push_ra_1(in_inst_ra_1), .push_ra_0(in_inst_ra_0), .push_wa(in_inst_wa),
    .push_imm(in_imm), .pop(inst_adv), .full_r(full_r), .head_vld(inst_vld),
    .head_op(inst_op), .head_ra_1(inst_ra_1), .head_ra_0(inst_ra_0),
    .head_wa(inst_wa), .head_imm(inst_imm)
  );

  // The destination and tag copies stay inside the dispatcher
  dispatcher u_dispatcher (
    .clk(clk), .rst(rst), .inst_vld(inst_vld), .inst_op(inst_op),
    .inst_ra_1(inst_ra_1), .inst_ra_0(inst_ra_0), .inst_wa(inst_wa),
    .inst_imm(inst_imm), .inst_adv(inst_adv), .arith_free(arith_free),
    .arith_free_idx(arith_free_idx), .logic_free(logic_free),
    .logic_free_idx(logic_free_idx), .arith_dis_vld(arith_dis_vld),
    .logic_dis_vld(logic_dis_vld), .dis_op(dis_op), .dis_imm(dis_imm),
    .dis_wa(), .dis_tag(), .dis_src_rdy(dis_src_rdy), .dis_src_val(dis_src_val),
    .dis_src_tag(dis_src_tag), .cdb_vld_r(cdb_vld_r), .cdb_tag_r(cdb_tag_r),
    .cdb_data_r(cdb_data_r), .lookup_tag(lookup_tag), .lookup_wa(lookup_wa)
  );

  reservation_station #(.STATION_ID(tomasulo_pkg::STATION_ARITH)) u_rs_arith (
    .clk(clk), .rst(rst), .dis_vld(arith_dis_vld), .dis_op(dis_op), .dis_imm(dis_imm),
    .dis_src_rdy(dis_src_rdy), .dis_src_val(dis_src_val), .dis_src_tag(dis_src_tag),
    .free(arith_free), .free_idx(arith_free_idx), .cdb_vld_r(cdb_vld_r),
    .cdb_tag_r(cdb_tag_r), .cdb_data_r(cdb_data_r), .iss_ready(arith_iss_ready),
    .iss_vld(arith_iss_vld), .iss_op(arith_iss_op), .iss_a(arith_iss_a),
    .iss_b(arith_iss_b), .iss_imm(arith_iss_imm), .iss_tag(arith_iss_tag)
  );

  reservation_station #(.STATION_ID(tomasulo_pkg::STATION_LOGIC)) u_rs_logic (
    .clk(clk), .rst(rst), .dis_vld(logic_dis_vld), .dis_op(dis_op), .dis_imm(dis_imm),
    .dis_src_rdy(dis_src_rdy), .dis_src_val(dis_src_val), .dis_src_tag(dis_src_tag),
    .free(logic_free), .free_idx(logic_free_idx), .cdb_vld_r(cdb_vld_r),
    .cdb_tag_r(cdb_tag_r), .cdb_data_r(cdb_data_r), .iss_ready(logic_iss_ready),
    .iss_vld(logic_iss_vld), .iss_op(logic_iss_op), .iss_a(logic_iss_a),
    .iss_b(logic_iss_b), .iss_imm(logic_iss_imm), .iss_tag(logic_iss_tag)
  );

  exe_arith #(.LATENCY(tomasulo_pkg::LATENCY_ARITH)) u_exe_arith (
    .clk(clk), .rst(rst), .iss_vld(arith_iss_vld), .iss_op(arith_iss_op),
    .iss_a(arith_iss_a), .iss_b(arith_iss_b), .iss_imm(arith_iss_imm),
    .iss_tag(arith_iss_tag), .iss_ready(arith_iss_ready), .cdb_gnt(gnt[0]),
    .cdb_req(req[0]), .res_tag(arith_res_tag), .res_data(arith_res_data)
  );

  exe_logic #(.LATENCY(tomasulo_pkg::LATENCY_LOGIC)) u_exe_logic (
    .clk(clk), .rst(rst), .iss_vld(logic_iss_vld), .iss_op(logic_iss_op),
    .iss_a(logic_iss_a), .iss_b(logic_iss_b), .iss_imm(logic_iss_imm),
    .iss_tag(logic_iss_tag), .iss_ready(logic_iss_ready), .cdb_gnt(gnt[1]),
    .cdb_req(req[1]), .res_tag(logic_res_tag), .res_data(logic_res_data)
  );

  cdb_arbiter u_arbiter (
    .clk(clk), .rst(rst), .req(req), .tag_0(arith_res_tag), .data_0(arith_res_data),
    .tag_1(logic_res_tag), .data_1(logic_res_data), .gnt(gnt),
    .lookup_tag(lookup_tag), .lookup_wa(lookup_wa), .cdb_vld_r(cdb_vld_r),
    .cdb_tag_r(cdb_tag_r), .cdb_wa_r(cdb_wa_r), .cdb_data_r(cdb_data_r)
  );

endmodule

`default_nettype wire

//--- test/tb_tomasulo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo;

  localparam int MAX_VEC = 64;
  localparam int COLS = 6;
  localparam int BURST_LEN = 30;
  localparam int QUIET_CYCLES = 20;

  logic                  clk;
  logic                  rst;
  logic                  in_pass;
  tomasulo_pkg::opcode_t in_inst_op;
  tomasulo_pkg::reg_t    in_inst_ra_1;
  tomasulo_pkg::reg_t    in_inst_ra_0;
  tomasulo_pkg::reg_t    in_inst_wa;
  logic [15:0]           in_imm;
  logic                  in_accept;
  logic                  out_vld_r;
  tomasulo_pkg::reg_t    out_wa_r;
  logic [15:0]           out_wdata_r;

  // Word 0 is the instruction count, then COLS words per instruction
  logic [15:0]        vec_mem [0:COLS*MAX_VEC];
  logic [MAX_VEC-1:0] matched;
  logic [15:0]        op_word;
  logic               saw_full;
  logic               offer;
  int                 vec_n;
  int                 sent;
  int                 bcast_cnt;
  int                 idle_cnt;
  int                 cycle_limit;
  int                 cycle_cnt = 0;

  tomasulo i_dut (
    .clk(clk), .rst(rst), .in_pass(in_pass), .in_inst_op(in_inst_op),
    .in_inst_ra_1(in_inst_ra_1), .in_inst_ra_0(in_inst_ra_0), .in_inst_wa(in_inst_wa),
    .in_imm(in_imm), .in_accept(in_accept), .out_vld_r(out_vld_r),
    .out_wa_r(out_wa_r), .out_wdata_r(out_wdata_r)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Columns are op, ra_1, ra_0, wa, imm and the expected result
  function automatic logic [15:0] field_of(input int idx, input int col);
    return vec_mem[1 + COLS * idx + col];
  endfunction

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // Results may leave in any order, so each broadcast claims one pending pair
  task automatic match_broadcast(input tomasulo_pkg::reg_t wa, input logic [15:0] data);
    int hit;
    int first;
    hit = -1;
    first = -1;
    for (int j = 0; j < vec_n; j++)
    begin
      if (!matched[j] && field_of(j, 3) == 16'(wa))
      begin
        if (first < 0)
          first = j;
        if (hit < 0 && field_of(j, 5) == data)
          hit = j;
      end
    end
    if (hit >= 0)
      matched[hit] = 1'b1;
    else if (first >= 0)
      compare_values($sformatf("result to r%0d", wa), field_of(first, 5), data);
    else
    begin
      $display("Broadcast of %0h to r%0d arrived with no pending write to that register",
               data, wa);
      $display("RESULT: FAIL");
      $fatal(1, "Unexpected broadcast");
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk)
  begin
    if (!rst && out_vld_r)
    begin
      match_broadcast(out_wa_r, out_wdata_r);
      bcast_cnt = bcast_cnt + 1;
      idle_cnt  = 0;
    end
    else
      idle_cnt = idle_cnt + 1;
  end

  always @(negedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout after %0d cycles with %0d of %0d results seen",
               cycle_cnt, bcast_cnt, vec_n);
      $display("RESULT: FAIL");
      $fatal(1, "Simulation timed out");
    end
  end

  initial
  begin
    rst          = 1'b1;
    in_pass      = 1'b0;
    in_inst_op   = tomasulo_pkg::OP_ADD;
    in_inst_ra_1 = '0;
    in_inst_ra_0 = '0;
    in_inst_wa   = '0;
    in_imm       = '0;
    matched      = '0;
    saw_full     = 1'b0;
    sent         = 0;
    bcast_cnt    = 0;
    idle_cnt     = 0;
    void'($urandom(3932));
    $readmemh("test/tomasulo_vectors.txt", vec_mem);
    vec_n       = int'(vec_mem[0]);
    cycle_limit = 40 * vec_n + 100;
    if (vec_n < BURST_LEN || vec_n > MAX_VEC)
    begin
      $display("Vector file holds %0d instructions, which is outside 30 to 64", vec_n);
      $display("RESULT: FAIL");
      $fatal(1, "Bad vector file");
    end

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare_values("reset out_vld_r", 32'd0, 32'(out_vld_r));
    compare_values("reset in_accept", 32'd1, 32'(in_accept));

    // Inputs hold from here until the next rising edge
    while (sent < vec_n)
    begin
      if (in_pass && in_accept)
        sent = sent + 1;
      if (!in_accept)
        saw_full = 1'b1;
      // A pending offer stays up and the last BURST_LEN go back to back
      offer = (sent < vec_n) && ((in_pass && !in_accept) || (sent >= vec_n - BURST_LEN)
              || ($urandom % 4) != 0);
      @(posedge clk);
      in_pass <= offer;
      if (offer)
      begin
        op_word = field_of(sent, 0);
        in_inst_op   <= tomasulo_pkg::opcode_t'(op_word[2:0]);
        in_inst_ra_1 <= tomasulo_pkg::reg_t'(field_of(sent, 1));
        in_inst_ra_0 <= tomasulo_pkg::reg_t'(field_of(sent, 2));
        in_inst_wa   <= tomasulo_pkg::reg_t'(field_of(sent, 3));
        in_imm       <= field_of(sent, 4);
      end
      @(negedge clk);
    end

    // The core has drained once no broadcast has shown for QUIET_CYCLES cycles
    wait (idle_cnt >= QUIET_CYCLES);
    compare_values("broadcast count", 32'(vec_n), 32'(bcast_cnt));
    compare_values("in_accept low during burst", 32'd1, 32'(saw_full));
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tomasulo_vectors.txt
// Columns are op ra_1 ra_0 wa imm expected, all hex, operand a is ra_0
// The first value is the instruction count
26
// Paced start covering every opcode
2 0 0 1 1234 1234
2 0 0 2 00ff 00ff
0 2 1 3 0000 1333
1 2 1 4 0000 1135
4 4 3 5 0000 1131
5 2 5 6 0000 11ff
6 1 6 7 0000 03cb
1 1 2 0 0000 eecb
// Burst of thirty opening with a long chain on r1
2 0 0 1 0010 0010
0 2 1 1 0000 010f
0 2 1 1 0000 020e
0 2 1 1 0000 030d
0 2 1 1 0000 040c
0 2 1 1 0000 050b
0 2 1 1 0000 060a
0 2 1 1 0000 0709
0 2 1 1 0000 0808
0 2 1 1 0000 0907
0 2 1 1 0000 0a06
0 2 1 1 0000 0b05
0 2 1 1 0000 0c04
6 7 1 3 0000 0fcf
2 0 0 3 0005 0005
0 3 3 4 0000 000a
1 4 1 5 0000 0bfa
4 6 5 6 0000 01fa
5 0 6 7 0000 effb
0 7 7 0 0000 dff6
0 1 0 1 0000 ebfa
1 0 1 2 0000 0c04
6 2 2 3 0000 0000
2 0 0 4 beef beef
4 1 4 5 0000 aaea
5 5 3 6 0000 aaea
0 4 6 7 0000 69d9
1 2 7 0 0000 5dd5
0 0 0 1 0000 bbaa
6 4 1 2 0000 0545

//--- tb.f
verilog/tomasulo_pkg.sv
verilog/inst_fifo.sv
verilog/dispatcher.sv
verilog/reservation_station.sv
verilog/exe_arith.sv
verilog/exe_logic.sv
verilog/cdb_arbiter.sv
verilog/tomasulo.sv
test/tb_tomasulo.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_tomasulo -f tb.f > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_tomasulo > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
